/* Makefile */
# Verilator build and run of the capture testbench

VERILATOR ?= verilator
TOP       ?= capture_top_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Verification passed$$"

clean:
	rm -rf $(BUILD_DIR)

/* build.f */
+incdir+include
source/capture_pkg.sv
source/level_discriminator.sv
source/capture_buffer.sv
source/readout_sequencer.sv
source/capture_top.sv
verif/capture_top_tb.sv

/* source/capture_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module capture_buffer #(
  parameter type payload_t = capture_pkg::sample_t,
  parameter int  DEPTH     = capture_pkg::SAMPLE_DEPTH
) (
  input  wire logic                ps_clk,
  input  wire logic                capture_reset,
  input  wire logic                clear_i,
  input  wire logic                we_i,
  input  wire payload_t            wdata_i,
  input  wire capture_pkg::count_t raddr_i,
  output payload_t                 rdata_o,
  output capture_pkg::count_t      count_o
);

  // storage, written in order from address zero
  payload_t            mem [DEPTH];

  // write pointer, also the fill count
  capture_pkg::count_t wr_ptr;
  logic                full;
  logic                do_write;

  // pointer saturates at the depth
  assign full = (wr_ptr == capture_pkg::count_t'(DEPTH));

  // clear wins over a write on the same edge
  assign do_write = we_i && !full && !clear_i;

  assign count_o = wr_ptr;

  always_ff @(posedge ps_clk) begin
    if (!capture_reset) begin
      wr_ptr <= '0;
    end else if (clear_i) begin
      wr_ptr <= '0;
    end else if (do_write) begin
      wr_ptr <= wr_ptr + capture_pkg::count_t'(1);
    end
  end

  // write port
  always_ff @(posedge ps_clk) begin
    if (do_write) begin
      mem[wr_ptr[$clog2(DEPTH)-1:0]] <= wdata_i;
    end
  end

  // registered read, data one cycle after the address
  always_ff @(posedge ps_clk) begin
    rdata_o <= mem[raddr_i[$clog2(DEPTH)-1:0]];
  end

endmodule

`default_nettype wire

/* source/capture_pkg.sv */
`default_nettype none

package capture_pkg;

  // adc sample width
  localparam int SAMPLE_WIDTH = 16;
  // timestamp is a sample index since arming
  localparam int TSTAMP_WIDTH = 24;
  // host readout word
  localparam int OUT_WIDTH = 32;

  // buffer capacities, both powers of two
  localparam int SAMPLE_DEPTH = 64;
  localparam int TSTAMP_DEPTH = 16;

  // fill counts and read addresses, wide enough for either depth
  localparam int COUNT_WIDTH = 16;

  // kept adc sample
  typedef logic [SAMPLE_WIDTH-1:0] sample_t;
  // sample index of a rising crossing
  typedef logic [TSTAMP_WIDTH-1:0] tstamp_t;
  // fill count or buffer address
  typedef logic [COUNT_WIDTH-1:0] count_t;
  // one word on the host port
  typedef logic [OUT_WIDTH-1:0] word_t;

endpackage

`default_nettype wire

/* source/capture_top.sv */
`timescale 1ns/1ps
`default_nettype none

module capture_top (
  input  wire logic                 ps_clk,
  input  wire logic                 capture_reset,
  input  wire logic                 sample_valid_i,
  input  wire capture_pkg::sample_t sample_i,
  input  wire capture_pkg::sample_t threshold_i,
  input  wire logic                 arm_i,
  input  wire logic                 stop_i,
  input  wire logic                 readout_start_i,
  input  wire logic                 out_ack_i,
  output logic                      out_req_o,
  output logic                      out_last_o,
  output capture_pkg::word_t        out_data_o
);

  // sequencer to discriminator and buffers
  logic                 capture_en;
  logic                 clear;
  capture_pkg::count_t  sample_raddr;
  capture_pkg::count_t  tstamp_raddr;
  // discriminator to buffers
  logic                 sample_we;
  capture_pkg::sample_t sample_wdata;
  logic                 tstamp_we;
  capture_pkg::tstamp_t tstamp_wdata;
  // buffers back to sequencer
  capture_pkg::sample_t sample_rdata;
  capture_pkg::tstamp_t tstamp_rdata;
  capture_pkg::count_t  sample_count;
  capture_pkg::count_t  tstamp_count;

  level_discriminator disc_i (
    .ps_clk         (ps_clk),
    .capture_reset  (capture_reset),
    .capture_en_i   (capture_en),
    .sample_valid_i (sample_valid_i),
    .sample_i       (sample_i),
    .threshold_i    (threshold_i),
    .sample_we_o    (sample_we),
    .sample_o       (sample_wdata),
    .tstamp_we_o    (tstamp_we),
    .tstamp_o       (tstamp_wdata)
  );

  // kept samples
  capture_buffer #(
    .payload_t (capture_pkg::sample_t),
    .DEPTH     (capture_pkg::SAMPLE_DEPTH)
  ) sample_buffer_i (
    .ps_clk        (ps_clk),
    .capture_reset (capture_reset),
    .clear_i       (clear),
    .we_i          (sample_we),
    .wdata_i       (sample_wdata),
    .raddr_i       (sample_raddr),
    .rdata_o       (sample_rdata),
    .count_o       (sample_count)
  );

  // crossing timestamps
  capture_buffer #(
    .payload_t (capture_pkg::tstamp_t),
    .DEPTH     (capture_pkg::TSTAMP_DEPTH)
  ) tstamp_buffer_i (
    .ps_clk        (ps_clk),
    .capture_reset (capture_reset),
    .clear_i       (clear),
    .we_i          (tstamp_we),
    .wdata_i       (tstamp_wdata),
    .raddr_i       (tstamp_raddr),
    .rdata_o       (tstamp_rdata),
    .count_o       (tstamp_count)
  );

  readout_sequencer seq_i (
    .ps_clk          (ps_clk),
    .capture_reset   (capture_reset),
    .arm_i           (arm_i),
    .stop_i          (stop_i),
    .readout_start_i (readout_start_i),
    .sample_count_i  (sample_count),
    .tstamp_count_i  (tstamp_count),
    .sample_rdata_i  (sample_rdata),
    .tstamp_rdata_i  (tstamp_rdata),
    .out_ack_i       (out_ack_i),
    .capture_en_o    (capture_en),
    .clear_o         (clear),
    .sample_raddr_o  (sample_raddr),
    .tstamp_raddr_o  (tstamp_raddr),
    .out_req_o       (out_req_o),
    .out_last_o      (out_last_o),
    .out_data_o      (out_data_o)
  );

endmodule

`default_nettype wire

/* source/level_discriminator.sv */
`timescale 1ns/1ps
`default_nettype none

module level_discriminator (
  input  wire logic                 ps_clk,
  input  wire logic                 capture_reset,
  input  wire logic                 capture_en_i,
  input  wire logic                 sample_valid_i,
  input  wire capture_pkg::sample_t sample_i,
  input  wire capture_pkg::sample_t threshold_i,
  output logic                      sample_we_o,
  output capture_pkg::sample_t      sample_o,
  output logic                      tstamp_we_o,
  output capture_pkg::tstamp_t      tstamp_o
);

  // capture_en from the previous cycle, for edge detect
  logic                 capture_en_q;
  // index of the next valid sample
  capture_pkg::tstamp_t index_q;
  // last valid sample was at or above threshold
  logic                 above_q;

  logic                 start;
  logic                 accept;
  logic                 above;
  logic                 prev_above;
  capture_pkg::tstamp_t index;

  // first active cycle after arming
  assign start = capture_en_i && !capture_en_q;
  assign accept = capture_en_i && sample_valid_i;
  assign above = (sample_i >= threshold_i);

  // on the first cycle, behave as if the index were zero
  // and the previous sample had been below threshold
  assign index = start ? '0 : index_q;
  assign prev_above = start ? 1'b0 : above_q;

  always_ff @(posedge ps_clk) begin
    if (!capture_reset) begin
      capture_en_q <= 1'b0;
      index_q <= '0;
      above_q <= 1'b0;
      sample_we_o <= 1'b0;
      tstamp_we_o <= 1'b0;
    end else begin
      capture_en_q <= capture_en_i;
      // registered compare, one cycle to the buffer write
      sample_we_o <= accept && above;
      // rising crossing through the threshold
      tstamp_we_o <= accept && above && !prev_above;
      if (accept) begin
        index_q <= index + capture_pkg::tstamp_t'(1);
        above_q <= above;
      end else if (start) begin
        // armed but no sample yet
        index_q <= '0;
        above_q <= 1'b0;
      end
    end
  end

  // payload follows the strobes
  always_ff @(posedge ps_clk) begin
    sample_o <= sample_i;
    tstamp_o <= index;
  end

endmodule

`default_nettype wire

/* source/readout_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module readout_sequencer (
  input  wire logic                 ps_clk,
  input  wire logic                 capture_reset,
  input  wire logic                 arm_i,
  input  wire logic                 stop_i,
  input  wire logic                 readout_start_i,
  input  wire capture_pkg::count_t  sample_count_i,
  input  wire capture_pkg::count_t  tstamp_count_i,
  input  wire capture_pkg::sample_t sample_rdata_i,
  input  wire capture_pkg::tstamp_t tstamp_rdata_i,
  input  wire logic                 out_ack_i,
  output logic                      capture_en_o,
  output logic                      clear_o,
  output capture_pkg::count_t       sample_raddr_o,
  output capture_pkg::count_t       tstamp_raddr_o,
  output logic                      out_req_o,
  output logic                      out_last_o,
  output capture_pkg::word_t        out_data_o
);

  // which part of the stream is being sent
  typedef enum logic [1:0] {SEC_IDLE, SEC_HDR, SEC_TS, SEC_SMP} section_t;
  // per-word phase
  typedef enum logic [1:0] {PH_ADDR, PH_FETCH, PH_REQ, PH_WAIT} phase_t;

  section_t            section;
  phase_t              phase;
  // counts frozen at the header
  capture_pkg::count_t ts_total;
  capture_pkg::count_t smp_total;

  logic                arm_ok;
  logic                start_ok;
  capture_pkg::count_t ts_next;
  capture_pkg::count_t smp_next;
  logic                ts_is_last;
  logic                smp_is_last;

  // no arming while a readout is running
  assign arm_ok = arm_i && (section == SEC_IDLE);
  // readout only once capture has stopped
  assign start_ok = readout_start_i && !capture_en_o && (section == SEC_IDLE);
  // buffers cleared on the arming edge
  assign clear_o = arm_ok;

  assign ts_next = tstamp_raddr_o + capture_pkg::count_t'(1);
  assign smp_next = sample_raddr_o + capture_pkg::count_t'(1);
  // last timestamp ends the stream only when no samples follow
  assign ts_is_last = (ts_next == ts_total) && (smp_total == '0);
  assign smp_is_last = (smp_next == smp_total);

  // capture state, stop has priority
  always_ff @(posedge ps_clk) begin
    if (!capture_reset) begin
      capture_en_o <= 1'b0;
    end else if (stop_i) begin
      capture_en_o <= 1'b0;
    end else if (arm_ok) begin
      capture_en_o <= 1'b1;
    end
  end

  always_ff @(posedge ps_clk) begin
    if (!capture_reset) begin
      section <= SEC_IDLE;
      phase <= PH_ADDR;
      ts_total <= '0;
      smp_total <= '0;
      tstamp_raddr_o <= '0;
      sample_raddr_o <= '0;
      out_req_o <= 1'b0;
      out_last_o <= 1'b0;
      out_data_o <= '0;
    end else begin
      case (phase)
        PH_ADDR: begin
          if (section == SEC_HDR) begin
            // last buffer write has landed by now
            ts_total <= tstamp_count_i;
            smp_total <= sample_count_i;
            out_data_o <= {tstamp_count_i, sample_count_i};
            // empty capture, header is the whole stream
            out_last_o <= (tstamp_count_i == '0) && (sample_count_i == '0);
            out_req_o <= 1'b1;
            phase <= PH_REQ;
          end else if (section != SEC_IDLE) begin
            // buffer samples the address on this edge
            phase <= PH_FETCH;
          end else if (start_ok) begin
            section <= SEC_HDR;
            tstamp_raddr_o <= '0;
            sample_raddr_o <= '0;
          end
        end
        PH_FETCH: begin
          // read data valid now, zero-extended onto the bus
          if (section == SEC_TS) begin
            out_data_o <= capture_pkg::word_t'(tstamp_rdata_i);
            out_last_o <= ts_is_last;
          end else begin
            out_data_o <= capture_pkg::word_t'(sample_rdata_i);
            out_last_o <= smp_is_last;
          end
          out_req_o <= 1'b1;
          phase <= PH_REQ;
        end
        PH_REQ: begin
          // hold data until the host acknowledges
          if (out_ack_i) begin
            out_req_o <= 1'b0;
            phase <= PH_WAIT;
          end
        end
        PH_WAIT: begin
          // ack must fall before the next word
          if (!out_ack_i) begin
            phase <= PH_ADDR;
            if (out_last_o) begin
              section <= SEC_IDLE;
              out_last_o <= 1'b0;
            end else if (section == SEC_HDR) begin
              section <= (ts_total != '0) ? SEC_TS : SEC_SMP;
            end else if (section == SEC_TS) begin
              if (ts_next == ts_total) begin
                section <= SEC_SMP;
              end else begin
                tstamp_raddr_o <= ts_next;
              end
            end else begin
              sample_raddr_o <= smp_next;
            end
          end
        end
        default: phase <= PH_ADDR;
      endcase
    end
  end

endmodule

`default_nettype wire

/* include/capture_tb_util.svh */
`ifndef CAPTURE_TB_UTIL_SVH
`define CAPTURE_TB_UTIL_SVH

// fibonacci lfsr state for taps x^16 + x^14 + x^13 + x^11
logic [15:0] lfsr_state = 16'd25;

// check totals for the closing line
int unsigned check_count = 0;
int unsigned error_count = 0;
int unsigned test_count = 0;

// take nbits from the lfsr with one step per bit
function automatic int unsigned lfsr_take(input int nbits);
  int unsigned value;
  logic        fb;
  value = 0;
  for (int i = 0; i < nbits; i++) begin
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    value = (value << 1) | int'(fb);
  end
  return value;
endfunction

// host word against the model
task automatic compare_word(input string what, input capture_pkg::word_t got,
                            input capture_pkg::word_t exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("mismatch %s: got %h, expected %h", what, got, exp);
  end
endtask

// fill count against the model
task automatic compare_count(input string what, input capture_pkg::count_t got,
                             input capture_pkg::count_t exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("mismatch %s: got %h, expected %h", what, got, exp);
  end
endtask

// single-bit flag against the model
task automatic compare_last(input string what, input logic got, input logic exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("mismatch %s: got %h, expected %h", what, got, exp);
  end
endtask

`endif

/* verif/capture_top_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module capture_top_tb;

  localparam int CLK_PERIOD = 100;
  // readouts in the run including the reread
  localparam int RUNS = 8;
  // longest capture in cycles with junk and gaps
  localparam int MAX_SAMPLES = 116;
  localparam int MAX_WORDS = 1 + capture_pkg::TSTAMP_DEPTH + capture_pkg::SAMPLE_DEPTH;
  localparam longint WATCHDOG_NS =
    longint'(RUNS) * (2 * MAX_SAMPLES + MAX_WORDS * 8) * CLK_PERIOD * 2 + 20000;

  logic                 ps_clk;
  logic                 capture_reset;
  logic                 sample_valid_i;
  capture_pkg::sample_t sample_i;
  capture_pkg::sample_t threshold_i;
  logic                 arm_i;
  logic                 stop_i;
  logic                 readout_start_i;
  logic                 out_ack_i;
  logic                 out_req_o;
  logic                 out_last_o;
  capture_pkg::word_t   out_data_o;

  // reference model state
  capture_pkg::sample_t model_smp[$];
  capture_pkg::tstamp_t model_ts[$];
  logic                 model_above;
  capture_pkg::tstamp_t model_index;
  capture_pkg::word_t   exp_words[$];
  // words seen by the host
  capture_pkg::word_t   got_words[$];
  logic                 got_last[$];
  int unsigned          errors_at_start;

  `include "capture_tb_util.svh"

  capture_top dut_i (
    .ps_clk          (ps_clk),
    .capture_reset   (capture_reset),
    .sample_valid_i  (sample_valid_i),
    .sample_i        (sample_i),
    .threshold_i     (threshold_i),
    .arm_i           (arm_i),
    .stop_i          (stop_i),
    .readout_start_i (readout_start_i),
    .out_ack_i       (out_ack_i),
    .out_req_o       (out_req_o),
    .out_last_o      (out_last_o),
    .out_data_o      (out_data_o)
  );

  initial begin
    ps_clk = 1'b0;
    forever #(CLK_PERIOD / 2) ps_clk = ~ps_clk;
  end

  // hard stop if the DUT stalls
  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run did not complete within %0d ns", WATCHDOG_NS);
    $display("Verification failed");
    $finish;
  end

  task automatic clear_model();
    model_smp = {};
    model_ts = {};
    model_above = 1'b0;
    model_index = '0;
  endtask

  // discriminator rules with buffers saturating at their depth
  task automatic predict_sample(input capture_pkg::sample_t s, input capture_pkg::sample_t thr);
    logic above;
    above = (s >= thr);
    if (above && !model_above && model_ts.size() < capture_pkg::TSTAMP_DEPTH) begin
      model_ts.push_back(model_index);
    end
    if (above && model_smp.size() < capture_pkg::SAMPLE_DEPTH) begin
      model_smp.push_back(s);
    end
    model_above = above;
    model_index = model_index + capture_pkg::tstamp_t'(1);
  endtask

  // header, then timestamps, then samples
  task automatic build_expected();
    exp_words = {};
    exp_words.push_back({capture_pkg::count_t'(model_ts.size()),
                         capture_pkg::count_t'(model_smp.size())});
    foreach (model_ts[i]) exp_words.push_back(capture_pkg::word_t'(model_ts[i]));
    foreach (model_smp[i]) exp_words.push_back(capture_pkg::word_t'(model_smp[i]));
  endtask

  // one clock with the host port quiet
  task automatic step_idle();
    @(negedge ps_clk);
    compare_last("out_req_o while idle", out_req_o, 1'b0);
    @(posedge ps_clk);
  endtask

  // samples outside a capture window
  task automatic send_junk(input int n);
    for (int i = 0; i < n; i++) begin
      sample_valid_i <= 1'b1;
      sample_i <= capture_pkg::sample_t'(lfsr_take(16));
      step_idle();
    end
    sample_valid_i <= 1'b0;
  endtask

  // mode 0 random, 1 alternating around 8000h, 2 below 8000h
  task automatic capture_run(input capture_pkg::sample_t thr, input int n, input int mode,
                             input bit force_first);
    capture_pkg::sample_t s;
    threshold_i <= thr;
    send_junk(3);
    arm_i <= 1'b1;
    step_idle();
    arm_i <= 1'b0;
    clear_model();
    for (int i = 0; i < n; i++) begin
      case (mode)
        1: s = (i % 2 == 1) ? {1'b1, 15'(lfsr_take(15))} : {1'b0, 15'(lfsr_take(15))};
        2: s = capture_pkg::sample_t'(lfsr_take(15));
        default: s = capture_pkg::sample_t'(lfsr_take(16));
      endcase
      // exactly at threshold counts as above
      if (force_first && i == 0) begin
        s = thr;
      end
      sample_valid_i <= 1'b1;
      sample_i <= s;
      predict_sample(s, thr);
      step_idle();
      // random valid gap
      if (lfsr_take(2) == 0) begin
        sample_valid_i <= 1'b0;
        step_idle();
      end
    end
    sample_valid_i <= 1'b0;
    stop_i <= 1'b1;
    step_idle();
    stop_i <= 1'b0;
    send_junk(3);
    build_expected();
  endtask

  // host side of the four-phase handshake
  task automatic read_stream();
    int unsigned delay;
    logic        seen_last;
    got_words = {};
    got_last = {};
    seen_last = 1'b0;
    readout_start_i <= 1'b1;
    @(posedge ps_clk);
    readout_start_i <= 1'b0;
    while (!seen_last && got_words.size() <= exp_words.size()) begin
      @(negedge ps_clk);
      if (out_req_o) begin
        got_words.push_back(out_data_o);
        got_last.push_back(out_last_o);
        seen_last = out_last_o;
        // slow acknowledge of 0 to 3 extra cycles
        delay = lfsr_take(2);
        repeat (delay) @(posedge ps_clk);
        @(posedge ps_clk);
        out_ack_i <= 1'b1;
        @(negedge ps_clk);
        while (out_req_o) begin
          @(negedge ps_clk);
        end
        @(posedge ps_clk);
        out_ack_i <= 1'b0;
      end
    end
    // sequencer sees ack low and returns to idle
    step_idle();
  endtask

  task automatic check_stream();
    int n;
    if (got_words.size() != exp_words.size()) begin
      error_count++;
      $display("readout returned %0d words where %0d were expected",
               got_words.size(), exp_words.size());
    end
    n = (got_words.size() < exp_words.size()) ? got_words.size() : exp_words.size();
    if (n > 0) begin
      compare_count("out_data_o[31:16] header", got_words[0][31:16], exp_words[0][31:16]);
      compare_count("out_data_o[15:0] header", got_words[0][15:0], exp_words[0][15:0]);
    end
    for (int i = 0; i < n; i++) begin
      compare_word($sformatf("out_data_o word %0d", i), got_words[i], exp_words[i]);
      compare_last($sformatf("out_last_o word %0d", i), got_last[i],
                   i == int'(exp_words.size()) - 1);
    end
  endtask

  task automatic begin_test();
    errors_at_start = error_count;
    test_count++;
  endtask

  task automatic end_test(input string name);
    if (error_count == errors_at_start) begin
      $display("test %0d %s: ok", test_count, name);
    end else begin
      $display("test %0d %s: %0d errors", test_count, name, error_count - errors_at_start);
    end
  endtask

  initial begin
    capture_reset = 1'b0;
    sample_valid_i = 1'b0;
    sample_i = '0;
    threshold_i = '0;
    arm_i = 1'b0;
    stop_i = 1'b0;
    readout_start_i = 1'b0;
    out_ack_i = 1'b0;
    repeat (3) @(posedge ps_clk);
    capture_reset <= 1'b1;

    // empty buffers after reset give the header alone
    begin_test();
    @(negedge ps_clk);
    compare_last("out_last_o after reset", out_last_o, 1'b0);
    step_idle();
    clear_model();
    build_expected();
    read_stream();
    check_stream();
    end_test("reset state");

    begin_test();
    capture_run(capture_pkg::sample_t'(lfsr_take(16)), 48, 0, 1'b0);
    read_stream();
    check_stream();
    end_test("random capture");

    // rising crossing at index zero
    begin_test();
    capture_run(16'h5000, 32, 0, 1'b1);
    read_stream();
    check_stream();
    end_test("crossing at index zero");

    begin_test();
    capture_run(16'hffff, 24, 2, 1'b0);
    read_stream();
    check_stream();
    end_test("nothing captured");

    // every sample kept so the sample buffer saturates
    begin_test();
    capture_run(16'h0000, 100, 0, 1'b0);
    read_stream();
    check_stream();
    end_test("sample overflow");

    // forty crossings overflow the timestamp buffer
    begin_test();
    capture_run(16'h8000, 80, 1, 1'b0);
    read_stream();
    check_stream();
    end_test("timestamp overflow");

    // second arm discards the first capture
    begin_test();
    capture_run(16'h1000, 30, 0, 1'b0);
    capture_run(16'hc000, 40, 0, 1'b0);
    read_stream();
    check_stream();
    end_test("re-arm");

    // same buffers with new ack delays
    begin_test();
    read_stream();
    check_stream();
    end_test("reread");

    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
